// ==== verilog/rs_issue_pkg.sv ====
package rs_issue_pkg;

    // data and address width, one word
    localparam int XLEN      = 32;
    // architectural register index
    localparam int REG_W     = 5;
    // reorder buffer tag, 0 = value present with no producer
    localparam int ROB_TAG_W = 4;

    // major opcodes handled by this stage
    typedef enum logic [6:0] {
        op_auipc = 7'b0010111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // alu operation, encoded as {instr[30], funct3}
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000,
        alu_sra = 4'b1101
    } alu_op_t;

    // where an instruction goes
    typedef enum logic [1:0] {
        cls_none = 2'd0,
        cls_alu  = 2'd1,
        cls_cmp  = 2'd2,
        cls_lsb  = 2'd3
    } issue_class_t;

    // funct3 values the decoder looks at
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_SR   = 3'b101;

endpackage

// ==== verilog/instr_fields.sv ====
`timescale 1ns/1ps

module instr_fields (
    input  logic [rs_issue_pkg::XLEN-1:0]  instr_i,
    output logic [rs_issue_pkg::REG_W-1:0] rs1_o,
    output logic [rs_issue_pkg::REG_W-1:0] rs2_o,
    output logic [rs_issue_pkg::REG_W-1:0] rd_o,
    output rs_issue_pkg::opcode_t          opcode_o,
    output logic [2:0]                     funct3_o,
    output rs_issue_pkg::alu_op_t          alu_op_o,
    output logic [rs_issue_pkg::XLEN-1:0]  imm_o,
    output rs_issue_pkg::issue_class_t     class_o,
    output logic                           writes_rd_o,
    output logic                           use_rs2_o
);
    import rs_issue_pkg::*;

    logic rd_zero;
    logic is_slt;
    logic f7_bit;

    // plain field slices
    assign rs1_o    = instr_i[19:15];
    assign rs2_o    = instr_i[24:20];
    assign rd_o     = instr_i[11:7];
    assign funct3_o = instr_i[14:12];
    assign opcode_o = opcode_t'(instr_i[6:0]);

    assign rd_zero = (instr_i[11:7] == '0);
    // slt and sltu are not supported
    assign is_slt  = (funct3_o == F3_SLT) || (funct3_o == F3_SLTU);
    assign f7_bit  = instr_i[30];

    always_comb begin
        // defaults cover unknown opcodes
        class_o     = cls_none;
        imm_o       = {{20{instr_i[31]}}, instr_i[31:20]};
        alu_op_o    = alu_add;
        writes_rd_o = 1'b0;
        use_rs2_o   = 1'b0;
        case (opcode_o)
            op_auipc: begin
                imm_o       = {instr_i[31:12], 12'h000};
                class_o     = rd_zero ? cls_none : cls_alu;
                writes_rd_o = 1'b1;
            end
            op_reg: begin
                // bit 30 picks sub and sra
                alu_op_o    = alu_op_t'({(funct3_o == F3_ADD || funct3_o == F3_SR) & f7_bit,
                                         funct3_o});
                class_o     = (rd_zero || is_slt) ? cls_none : cls_alu;
                writes_rd_o = 1'b1;
                use_rs2_o   = 1'b1;
            end
            op_imm: begin
                // bit 30 only for srai
                alu_op_o    = alu_op_t'({(funct3_o == F3_SR) & f7_bit, funct3_o});
                class_o     = (rd_zero || is_slt) ? cls_none : cls_alu;
                writes_rd_o = 1'b1;
            end
            op_br: begin
                imm_o     = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                             instr_i[11:8], 1'b0};
                class_o   = cls_cmp;
                use_rs2_o = 1'b1;
            end
            op_load: begin
                class_o     = rd_zero ? cls_none : cls_lsb;
                writes_rd_o = 1'b1;
            end
            op_store: begin
                // store has no rd, rd field is offset bits
                imm_o     = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                class_o   = cls_lsb;
                use_rs2_o = 1'b1;
            end
            default: begin
                class_o = cls_none;
            end
        endcase
    end

endmodule

// ==== verilog/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass #(
    parameter int ROB_DEPTH = 16
) (
    input  logic [rs_issue_pkg::XLEN-1:0]           rf_value_i,
    input  logic [rs_issue_pkg::ROB_TAG_W-1:0]      rf_tag_i,
    input  logic [ROB_DEPTH*rs_issue_pkg::XLEN-1:0] rob_value_i,
    input  logic [ROB_DEPTH-1:0]                    rob_ready_i,
    output logic [rs_issue_pkg::XLEN-1:0]           value_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0]      tag_o
);
    import rs_issue_pkg::*;

    logic in_range;
    logic hit;

    // tags above the buffer size never name an entry
    assign in_range = (int'(rf_tag_i) < ROB_DEPTH);

    // producer already finished, value sits in the rob
    assign hit = (rf_tag_i != '0) && in_range && rob_ready_i[rf_tag_i];

    always_comb begin
        if (hit) begin
            value_o = rob_value_i[rf_tag_i*XLEN +: XLEN];
            tag_o   = '0;
        end else begin
            // register file value and tag unchanged
            value_o = rf_value_i;
            tag_o   = rf_tag_i;
        end
    end

endmodule

// ==== verilog/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                instr_valid_i,
    input  rs_issue_pkg::issue_class_t          class_i,
    input  logic                                writes_rd_i,
    input  logic                                alu_full_i,
    input  logic                                cmp_full_i,
    input  logic                                lsb_full_i,
    input  logic [rs_issue_pkg::ROB_TAG_W-1:0]  rob_free_tag_i,
    output logic                                iqueue_read_o,
    output logic                                load_tag_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0]  tag_o,
    output logic                                alu_go_o,
    output logic                                cmp_go_o,
    output logic                                lsb_go_o
);
    import rs_issue_pkg::*;

    logic enable;
    logic station_free;
    logic rob_free;
    logic issue;
    logic discard;

    // nothing leaves the queue during reset
    assign enable = instr_valid_i && !rst;

    // target station of this class has room
    always_comb begin
        case (class_i)
            cls_alu: station_free = !alu_full_i;
            cls_cmp: station_free = !cmp_full_i;
            cls_lsb: station_free = !lsb_full_i;
            default: station_free = 1'b0;
        endcase
    end

    // free tag of zero means rob is full
    assign rob_free = (rob_free_tag_i != '0);

    assign issue   = enable && (class_i != cls_none) && station_free && rob_free;
    // unsupported or rd=0 encodings are dropped
    assign discard = enable && (class_i == cls_none);

    assign iqueue_read_o = issue || discard;

    // rename rd to the allocated entry
    assign load_tag_o = issue && writes_rd_i;
    assign tag_o      = rob_free_tag_i;

    // one load strobe per target
    assign alu_go_o = issue && (class_i == cls_alu);
    assign cmp_go_o = issue && (class_i == cls_cmp);
    assign lsb_go_o = issue && (class_i == cls_lsb);

endmodule

// ==== verilog/issue_regs.sv ====
`timescale 1ns/1ps

module issue_regs (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               alu_go_i,
    input  logic                               cmp_go_i,
    input  logic                               lsb_go_i,
    input  logic [rs_issue_pkg::XLEN-1:0]      pc_i,
    input  rs_issue_pkg::opcode_t              opcode_i,
    input  logic [2:0]                         funct3_i,
    input  rs_issue_pkg::alu_op_t              alu_op_i,
    input  logic [rs_issue_pkg::XLEN-1:0]      imm_i,
    input  logic [rs_issue_pkg::REG_W-1:0]     rd_i,
    input  logic                               use_rs2_i,
    input  logic [rs_issue_pkg::XLEN-1:0]      v1_i,
    input  logic [rs_issue_pkg::ROB_TAG_W-1:0] t1_i,
    input  logic [rs_issue_pkg::XLEN-1:0]      v2_i,
    input  logic [rs_issue_pkg::ROB_TAG_W-1:0] t2_i,
    input  logic [rs_issue_pkg::ROB_TAG_W-1:0] rob_tag_i,
    // alu station
    output logic                               alu_valid_o,
    output rs_issue_pkg::alu_op_t              alu_op_o,
    output logic [rs_issue_pkg::XLEN-1:0]      alu_v1_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0] alu_t1_o,
    output logic [rs_issue_pkg::XLEN-1:0]      alu_v2_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0] alu_t2_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0] alu_rob_o,
    // compare station, branches only
    output logic                               cmp_valid_o,
    output logic [2:0]                         cmp_op_o,
    output logic [rs_issue_pkg::XLEN-1:0]      cmp_v1_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0] cmp_t1_o,
    output logic [rs_issue_pkg::XLEN-1:0]      cmp_v2_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0] cmp_t2_o,
    output logic [rs_issue_pkg::XLEN-1:0]      cmp_pc_o,
    output logic [rs_issue_pkg::XLEN-1:0]      cmp_imm_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0] cmp_rob_o,
    // load-store buffer
    output logic                               lsb_valid_o,
    output logic                               lsb_store_o,
    output logic [2:0]                         lsb_funct_o,
    output logic [rs_issue_pkg::XLEN-1:0]      lsb_base_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0] lsb_base_tag_o,
    output logic [rs_issue_pkg::XLEN-1:0]      lsb_data_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0] lsb_data_tag_o,
    output logic [rs_issue_pkg::XLEN-1:0]      lsb_offset_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0] lsb_rob_o,
    // reorder buffer allocation
    output logic                               rob_write_o,
    output logic [rs_issue_pkg::XLEN-1:0]      rob_pc_o,
    output rs_issue_pkg::opcode_t              rob_opcode_o,
    output logic [rs_issue_pkg::REG_W-1:0]     rob_rd_o
);
    import rs_issue_pkg::*;

    logic any_go;

    assign any_go = alu_go_i || cmp_go_i || lsb_go_i;

    // valid pulses, one cycle each
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid_o <= 1'b0;
            cmp_valid_o <= 1'b0;
            lsb_valid_o <= 1'b0;
            rob_write_o <= 1'b0;
        end else begin
            alu_valid_o <= alu_go_i;
            cmp_valid_o <= cmp_go_i;
            lsb_valid_o <= lsb_go_i;
            rob_write_o <= any_go;
        end
    end

    // alu payload
    always_ff @(posedge clk) begin
        if (alu_go_i) begin
            alu_op_o  <= alu_op_i;
            alu_rob_o <= rob_tag_i;
            if (opcode_i == op_auipc) begin
                // pc + upper immediate
                alu_v1_o <= pc_i;
                alu_t1_o <= '0;
                alu_v2_o <= imm_i;
                alu_t2_o <= '0;
            end else begin
                alu_v1_o <= v1_i;
                alu_t1_o <= t1_i;
                // immediate forms have no rs2
                alu_v2_o <= use_rs2_i ? v2_i : imm_i;
                alu_t2_o <= use_rs2_i ? t2_i : '0;
            end
        end
    end

    // compare payload, op is the branch funct3
    always_ff @(posedge clk) begin
        if (cmp_go_i) begin
            cmp_op_o  <= funct3_i;
            cmp_v1_o  <= v1_i;
            cmp_t1_o  <= t1_i;
            cmp_v2_o  <= v2_i;
            cmp_t2_o  <= t2_i;
            cmp_pc_o  <= pc_i;
            cmp_imm_o <= imm_i;
            cmp_rob_o <= rob_tag_i;
        end
    end

    // load-store payload
    always_ff @(posedge clk) begin
        if (lsb_go_i) begin
            lsb_store_o    <= (opcode_i == op_store);
            lsb_funct_o    <= funct3_i;
            lsb_base_o     <= v1_i;
            lsb_base_tag_o <= t1_i;
            // loads carry no data operand
            lsb_data_o     <= use_rs2_i ? v2_i : '0;
            lsb_data_tag_o <= use_rs2_i ? t2_i : '0;
            lsb_offset_o   <= imm_i;
            lsb_rob_o      <= rob_tag_i;
        end
    end

    // rob entry info, any issued instruction
    always_ff @(posedge clk) begin
        if (any_go) begin
            rob_pc_o     <= pc_i;
            rob_opcode_o <= opcode_i;
            rob_rd_o     <= rd_i;
        end
    end

endmodule

// ==== verilog/rv32_issue.sv ====
`timescale 1ns/1ps

module rv32_issue #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                                    clk,
    input  logic                                    rst,
    // instruction queue
    input  logic                                    instr_valid_i,
    input  logic [rs_issue_pkg::XLEN-1:0]           instr_i,
    input  logic [rs_issue_pkg::XLEN-1:0]           pc_i,
    output logic                                    iqueue_read_o,
    // register file
    output logic [rs_issue_pkg::REG_W-1:0]          rs1_o,
    output logic [rs_issue_pkg::REG_W-1:0]          rs2_o,
    input  logic [rs_issue_pkg::XLEN-1:0]           rf_v1_i,
    input  logic [rs_issue_pkg::ROB_TAG_W-1:0]      rf_t1_i,
    input  logic [rs_issue_pkg::XLEN-1:0]           rf_v2_i,
    input  logic [rs_issue_pkg::ROB_TAG_W-1:0]      rf_t2_i,
    output logic [rs_issue_pkg::REG_W-1:0]          rd_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0]      tag_o,
    output logic                                    load_tag_o,
    // reorder buffer
    input  logic [rs_issue_pkg::ROB_TAG_W-1:0]      rob_free_tag_i,
    input  logic [ROB_DEPTH*rs_issue_pkg::XLEN-1:0] rob_value_i,
    input  logic [ROB_DEPTH-1:0]                    rob_ready_i,
    output logic                                    rob_write_o,
    output logic [rs_issue_pkg::XLEN-1:0]           rob_pc_o,
    output rs_issue_pkg::opcode_t                   rob_opcode_o,
    output logic [rs_issue_pkg::REG_W-1:0]          rob_rd_o,
    // alu station
    input  logic                                    alu_full_i,
    output logic                                    alu_valid_o,
    output rs_issue_pkg::alu_op_t                   alu_op_o,
    output logic [rs_issue_pkg::XLEN-1:0]           alu_v1_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0]      alu_t1_o,
    output logic [rs_issue_pkg::XLEN-1:0]           alu_v2_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0]      alu_t2_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0]      alu_rob_o,
    // compare station
    input  logic                                    cmp_full_i,
    output logic                                    cmp_valid_o,
    output logic [2:0]                              cmp_op_o,
    output logic [rs_issue_pkg::XLEN-1:0]           cmp_v1_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0]      cmp_t1_o,
    output logic [rs_issue_pkg::XLEN-1:0]           cmp_v2_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0]      cmp_t2_o,
    output logic [rs_issue_pkg::XLEN-1:0]           cmp_pc_o,
    output logic [rs_issue_pkg::XLEN-1:0]           cmp_imm_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0]      cmp_rob_o,
    // load-store buffer
    input  logic                                    lsb_full_i,
    output logic                                    lsb_valid_o,
    output logic                                    lsb_store_o,
    output logic [2:0]                              lsb_funct_o,
    output logic [rs_issue_pkg::XLEN-1:0]           lsb_base_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0]      lsb_base_tag_o,
    output logic [rs_issue_pkg::XLEN-1:0]           lsb_data_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0]      lsb_data_tag_o,
    output logic [rs_issue_pkg::XLEN-1:0]           lsb_offset_o,
    output logic [rs_issue_pkg::ROB_TAG_W-1:0]      lsb_rob_o
);
    import rs_issue_pkg::*;

    opcode_t               opcode;
    logic [2:0]            funct3;
    alu_op_t               alu_op;
    logic [XLEN-1:0]       imm;
    issue_class_t          cls;
    logic                  writes_rd;
    logic                  use_rs2;
    logic                  alu_go;
    logic                  cmp_go;
    logic                  lsb_go;
    // per source operand, index 0 = rs1
    logic [XLEN-1:0]       rf_val [2];
    logic [ROB_TAG_W-1:0]  rf_tag [2];
    logic [XLEN-1:0]       src_val [2];
    logic [ROB_TAG_W-1:0]  src_tag [2];

    assign rf_val[0] = rf_v1_i;
    assign rf_val[1] = rf_v2_i;
    assign rf_tag[0] = rf_t1_i;
    assign rf_tag[1] = rf_t2_i;

    instr_fields u_fields (
        .instr_i     (instr_i),
        .rs1_o       (rs1_o),
        .rs2_o       (rs2_o),
        .rd_o        (rd_o),
        .opcode_o    (opcode),
        .funct3_o    (funct3),
        .alu_op_o    (alu_op),
        .imm_o       (imm),
        .class_o     (cls),
        .writes_rd_o (writes_rd),
        .use_rs2_o   (use_rs2)
    );

    // rob forwarding for both sources
    for (genvar g = 0; g < 2; g++) begin : g_src
        operand_bypass #(
            .ROB_DEPTH (ROB_DEPTH)
        ) u_bypass (
            .rf_value_i  (rf_val[g]),
            .rf_tag_i    (rf_tag[g]),
            .rob_value_i (rob_value_i),
            .rob_ready_i (rob_ready_i),
            .value_o     (src_val[g]),
            .tag_o       (src_tag[g])
        );
    end

    issue_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .instr_valid_i  (instr_valid_i),
        .class_i        (cls),
        .writes_rd_i    (writes_rd),
        .alu_full_i     (alu_full_i),
        .cmp_full_i     (cmp_full_i),
        .lsb_full_i     (lsb_full_i),
        .rob_free_tag_i (rob_free_tag_i),
        .iqueue_read_o  (iqueue_read_o),
        .load_tag_o     (load_tag_o),
        .tag_o          (tag_o),
        .alu_go_o       (alu_go),
        .cmp_go_o       (cmp_go),
        .lsb_go_o       (lsb_go)
    );

    issue_regs u_regs (
        .clk            (clk),
        .rst            (rst),
        .alu_go_i       (alu_go),
        .cmp_go_i       (cmp_go),
        .lsb_go_i       (lsb_go),
        .pc_i           (pc_i),
        .opcode_i       (opcode),
        .funct3_i       (funct3),
        .alu_op_i       (alu_op),
        .imm_i          (imm),
        .rd_i           (rd_o),
        .use_rs2_i      (use_rs2),
        .v1_i           (src_val[0]),
        .t1_i           (src_tag[0]),
        .v2_i           (src_val[1]),
        .t2_i           (src_tag[1]),
        .rob_tag_i      (rob_free_tag_i),
        .alu_valid_o    (alu_valid_o),
        .alu_op_o       (alu_op_o),
        .alu_v1_o       (alu_v1_o),
        .alu_t1_o       (alu_t1_o),
        .alu_v2_o       (alu_v2_o),
        .alu_t2_o       (alu_t2_o),
        .alu_rob_o      (alu_rob_o),
        .cmp_valid_o    (cmp_valid_o),
        .cmp_op_o       (cmp_op_o),
        .cmp_v1_o       (cmp_v1_o),
        .cmp_t1_o       (cmp_t1_o),
        .cmp_v2_o       (cmp_v2_o),
        .cmp_t2_o       (cmp_t2_o),
        .cmp_pc_o       (cmp_pc_o),
        .cmp_imm_o      (cmp_imm_o),
        .cmp_rob_o      (cmp_rob_o),
        .lsb_valid_o    (lsb_valid_o),
        .lsb_store_o    (lsb_store_o),
        .lsb_funct_o    (lsb_funct_o),
        .lsb_base_o     (lsb_base_o),
        .lsb_base_tag_o (lsb_base_tag_o),
        .lsb_data_o     (lsb_data_o),
        .lsb_data_tag_o (lsb_data_tag_o),
        .lsb_offset_o   (lsb_offset_o),
        .lsb_rob_o      (lsb_rob_o),
        .rob_write_o    (rob_write_o),
        .rob_pc_o       (rob_pc_o),
        .rob_opcode_o   (rob_opcode_o),
        .rob_rd_o       (rob_rd_o)
    );

endmodule

// ==== tests/rv32_issue_sva.sv ====
`timescale 1ns/1ps

module rv32_issue_sva (
    input logic clk,
    input logic rst,
    input logic iqueue_read_o,
    input logic load_tag_o,
    input logic alu_valid_o,
    input logic cmp_valid_o,
    input logic lsb_valid_o,
    input logic rob_write_o
);

    // one instruction per cycle means one station at most
    a_one_station: assert property (@(posedge clk) disable iff (rst)
        $onehot0({alu_valid_o, cmp_valid_o, lsb_valid_o}))
        else $error("more than one station valid in the same cycle");

    // every issued instruction allocates a rob entry
    a_rob_write: assert property (@(posedge clk) disable iff (rst)
        rob_write_o == (alu_valid_o || cmp_valid_o || lsb_valid_o))
        else $error("rob_write_o does not match the station valids");

    // rename only for a consumed instruction
    a_rename_read: assert property (@(posedge clk) disable iff (rst)
        load_tag_o |-> iqueue_read_o)
        else $error("load_tag_o high without iqueue_read_o");

endmodule

// attach to every instance of the top level
bind rv32_issue rv32_issue_sva u_sva (.*);

// ==== tests/rv32_issue_tb.sv ====
`timescale 1ns/1ps

module rv32_issue_tb;
    import rs_issue_pkg::*;

    localparam int ROB_DEPTH = 16;
    localparam int N_INSTR   = 500;
    localparam int MAX_WAIT  = 60;

    logic                      clk;
    logic                      rst;
    logic                      instr_valid_i;
    logic [XLEN-1:0]           instr_i;
    logic [XLEN-1:0]           pc_i;
    logic                      iqueue_read_o;
    logic                      load_tag_o;
    logic [REG_W-1:0]          rs1_o;
    logic [REG_W-1:0]          rs2_o;
    logic [REG_W-1:0]          rd_o;
    logic [XLEN-1:0]           rf_v1_i;
    logic [XLEN-1:0]           rf_v2_i;
    logic [ROB_TAG_W-1:0]      rf_t1_i;
    logic [ROB_TAG_W-1:0]      rf_t2_i;
    logic [ROB_TAG_W-1:0]      tag_o;
    logic [ROB_TAG_W-1:0]      rob_free_tag_i;
    logic [ROB_DEPTH*XLEN-1:0] rob_value_i;
    logic [ROB_DEPTH-1:0]      rob_ready_i;
    logic                      rob_write_o;
    logic [XLEN-1:0]           rob_pc_o;
    opcode_t                   rob_opcode_o;
    logic [REG_W-1:0]          rob_rd_o;
    logic                      alu_full_i;
    logic                      cmp_full_i;
    logic                      lsb_full_i;
    logic                      alu_valid_o;
    logic                      cmp_valid_o;
    logic                      lsb_valid_o;
    logic                      lsb_store_o;
    alu_op_t                   alu_op_o;
    logic [2:0]                cmp_op_o;
    logic [2:0]                lsb_funct_o;
    logic [XLEN-1:0]           alu_v1_o;
    logic [XLEN-1:0]           alu_v2_o;
    logic [XLEN-1:0]           cmp_v1_o;
    logic [XLEN-1:0]           cmp_v2_o;
    logic [XLEN-1:0]           cmp_pc_o;
    logic [XLEN-1:0]           cmp_imm_o;
    logic [XLEN-1:0]           lsb_base_o;
    logic [XLEN-1:0]           lsb_data_o;
    logic [XLEN-1:0]           lsb_offset_o;
    logic [ROB_TAG_W-1:0]      alu_t1_o;
    logic [ROB_TAG_W-1:0]      alu_t2_o;
    logic [ROB_TAG_W-1:0]      alu_rob_o;
    logic [ROB_TAG_W-1:0]      cmp_t1_o;
    logic [ROB_TAG_W-1:0]      cmp_t2_o;
    logic [ROB_TAG_W-1:0]      cmp_rob_o;
    logic [ROB_TAG_W-1:0]      lsb_base_tag_o;
    logic [ROB_TAG_W-1:0]      lsb_data_tag_o;
    logic [ROB_TAG_W-1:0]      lsb_rob_o;

    // model expectation for the cycle after the edge
    issue_class_t              last_cls;
    logic [XLEN-1:0]           exp_v1;
    logic [XLEN-1:0]           exp_v2;
    logic [XLEN-1:0]           exp_imm;
    logic [XLEN-1:0]           exp_pc;
    logic [ROB_TAG_W-1:0]      exp_t1;
    logic [ROB_TAG_W-1:0]      exp_t2;
    logic [ROB_TAG_W-1:0]      exp_rob;
    logic [3:0]                exp_aop;
    logic [2:0]                exp_f3;
    logic [6:0]                exp_opc;
    logic [REG_W-1:0]          exp_rd;
    int                        errors;
    int                        checks;

    rv32_issue #(.ROB_DEPTH(ROB_DEPTH)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // kept opcodes plus lui, jal and jalr
    function automatic logic [XLEN-1:0] rand_instr();
        logic [6:0]      ops [9];
        logic [XLEN-1:0] ins;
        ops = '{op_auipc, op_br, op_load, op_store, op_imm, op_reg,
                7'b0110111, 7'b1101111, 7'b1100111};
        ins = $urandom;
        ins[6:0] = ops[$urandom % 9];
        // rd of zero more often than by chance
        if (($urandom % 8) == 0) begin
            ins[11:7] = '0;
        end
        return ins;
    endfunction

    function automatic issue_class_t model_class(input logic [XLEN-1:0] ins);
        logic rd_nz;
        logic slt;
        rd_nz = (ins[11:7] != 0);
        // funct3 010 and 011
        slt = (ins[14:13] == 2'b01);
        case (ins[6:0])
            op_auipc: return rd_nz ? cls_alu : cls_none;
            op_reg:   return (rd_nz && !slt) ? cls_alu : cls_none;
            op_imm:   return (rd_nz && !slt) ? cls_alu : cls_none;
            op_load:  return rd_nz ? cls_lsb : cls_none;
            op_store: return cls_lsb;
            op_br:    return cls_cmp;
            default:  return cls_none;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] model_imm(input logic [XLEN-1:0] ins);
        case (ins[6:0])
            op_auipc: return {ins[31:12], 12'h000};
            op_store: return {{20{ins[31]}}, ins[31:25], ins[11:7]};
            op_br:    return {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            default:  return {{20{ins[31]}}, ins[31:20]};
        endcase
    endfunction

    // {bit 30, funct3} where bit 30 counts only for sub, sra and srai
    function automatic logic [3:0] model_aop(input logic [XLEN-1:0] ins);
        logic [2:0] f3;
        f3 = ins[14:12];
        case (ins[6:0])
            op_reg:  return {ins[30] && (f3 == 3'b000 || f3 == 3'b101), f3};
            op_imm:  return {ins[30] && (f3 == 3'b101), f3};
            default: return 4'b0000;
        endcase
    endfunction

    // ready rob entry replaces the register file value
    task automatic forward(input logic [XLEN-1:0] rv, input logic [ROB_TAG_W-1:0] rt,
                           output logic [XLEN-1:0] v, output logic [ROB_TAG_W-1:0] t);
        if (rt != 0 && rob_ready_i[rt]) begin
            v = rob_value_i[rt*XLEN +: XLEN];
            t = '0;
        end else begin
            v = rv;
            t = rt;
        end
    endtask

    task automatic drive_env();
        instr_valid_i = (($urandom % 8) != 0);
        rf_v1_i = $urandom;
        rf_v2_i = $urandom;
        rf_t1_i = ($urandom % 2) ? 4'($urandom) : '0;
        rf_t2_i = ($urandom % 2) ? 4'($urandom) : '0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            rob_value_i[i*XLEN +: XLEN] = $urandom;
        end
        rob_ready_i = $urandom;
        alu_full_i = (($urandom % 4) == 0);
        cmp_full_i = (($urandom % 4) == 0);
        lsb_full_i = (($urandom % 4) == 0);
        // zero free tag now and then means rob full
        rob_free_tag_i = (($urandom % 8) == 0) ? '0 : 4'(1 + $urandom % 15);
    endtask

    // registered outputs sampled at the falling edge
    task automatic check_issued();
        check_val("alu_valid_o", alu_valid_o, last_cls == cls_alu);
        check_val("cmp_valid_o", cmp_valid_o, last_cls == cls_cmp);
        check_val("lsb_valid_o", lsb_valid_o, last_cls == cls_lsb);
        check_val("rob_write_o", rob_write_o, last_cls != cls_none);
        if (last_cls == cls_alu) begin
            check_val("alu_op_o", alu_op_o, exp_aop);
            check_val("alu_v1_o", alu_v1_o, exp_v1);
            check_val("alu_t1_o", alu_t1_o, exp_t1);
            check_val("alu_v2_o", alu_v2_o, exp_v2);
            check_val("alu_t2_o", alu_t2_o, exp_t2);
            check_val("alu_rob_o", alu_rob_o, exp_rob);
        end
        if (last_cls == cls_cmp) begin
            check_val("cmp_op_o", cmp_op_o, exp_f3);
            check_val("cmp_v1_o", cmp_v1_o, exp_v1);
            check_val("cmp_t1_o", cmp_t1_o, exp_t1);
            check_val("cmp_v2_o", cmp_v2_o, exp_v2);
            check_val("cmp_t2_o", cmp_t2_o, exp_t2);
            check_val("cmp_pc_o", cmp_pc_o, exp_pc);
            check_val("cmp_imm_o", cmp_imm_o, exp_imm);
            check_val("cmp_rob_o", cmp_rob_o, exp_rob);
        end
        if (last_cls == cls_lsb) begin
            check_val("lsb_store_o", lsb_store_o, exp_opc == op_store);
            check_val("lsb_funct_o", lsb_funct_o, exp_f3);
            check_val("lsb_base_o", lsb_base_o, exp_v1);
            check_val("lsb_base_tag_o", lsb_base_tag_o, exp_t1);
            check_val("lsb_data_o", lsb_data_o, exp_v2);
            check_val("lsb_data_tag_o", lsb_data_tag_o, exp_t2);
            check_val("lsb_offset_o", lsb_offset_o, exp_imm);
            check_val("lsb_rob_o", lsb_rob_o, exp_rob);
        end
        if (last_cls != cls_none) begin
            check_val("rob_pc_o", rob_pc_o, exp_pc);
            check_val("rob_opcode_o", rob_opcode_o, exp_opc);
            check_val("rob_rd_o", rob_rd_o, exp_rd);
        end
    endtask

    // combinational checks plus expectation for the next cycle
    task automatic model_cycle(output logic consumed);
        issue_class_t         cls;
        logic                 free;
        logic                 issue;
        logic                 wrd;
        logic [6:0]           opc;
        logic [XLEN-1:0]      v1;
        logic [XLEN-1:0]      v2;
        logic [ROB_TAG_W-1:0] t1;
        logic [ROB_TAG_W-1:0] t2;
        opc = instr_i[6:0];
        cls = model_class(instr_i);
        wrd = (opc == op_auipc) || (opc == op_reg) || (opc == op_imm) || (opc == op_load);
        case (cls)
            cls_alu: free = !alu_full_i;
            cls_cmp: free = !cmp_full_i;
            cls_lsb: free = !lsb_full_i;
            default: free = 1'b0;
        endcase
        issue = instr_valid_i && (cls != cls_none) && free && (rob_free_tag_i != 0);
        consumed = issue || (instr_valid_i && cls == cls_none);
        check_val("iqueue_read_o", iqueue_read_o, consumed);
        check_val("load_tag_o", load_tag_o, issue && wrd);
        check_val("rs1_o", rs1_o, instr_i[19:15]);
        check_val("rs2_o", rs2_o, instr_i[24:20]);
        check_val("rd_o", rd_o, instr_i[11:7]);
        if (issue && wrd) begin
            check_val("tag_o", tag_o, rob_free_tag_i);
        end
        forward(rf_v1_i, rf_t1_i, v1, t1);
        forward(rf_v2_i, rf_t2_i, v2, t2);
        last_cls = issue ? cls : cls_none;
        exp_pc   = pc_i;
        exp_opc  = opc;
        exp_rd   = instr_i[11:7];
        exp_f3   = instr_i[14:12];
        exp_rob  = rob_free_tag_i;
        exp_imm  = model_imm(instr_i);
        exp_aop  = model_aop(instr_i);
        exp_v1   = v1;
        exp_t1   = t1;
        exp_v2   = v2;
        exp_t2   = t2;
        if (opc == op_auipc) begin
            // pc plus upper immediate
            exp_v1 = pc_i;
            exp_t1 = '0;
            exp_v2 = exp_imm;
            exp_t2 = '0;
        end else if (opc == op_imm) begin
            exp_v2 = exp_imm;
            exp_t2 = '0;
        end else if (opc == op_load) begin
            exp_v2 = '0;
            exp_t2 = '0;
        end
    endtask

    initial begin
        logic            consumed;
        logic            hung;
        logic [XLEN-1:0] cur;
        logic [XLEN-1:0] cur_pc;
        int              waited;
        void'($urandom(32'hca1becf3));
        errors = 0;
        checks = 0;
        hung = 1'b0;
        last_cls = cls_none;
        rst = 1'b1;
        // valid high so reset gating is seen
        instr_valid_i = 1'b1;
        instr_i = 32'h00100093;
        pc_i = '0;
        rf_v1_i = '0;
        rf_v2_i = '0;
        rf_t1_i = '0;
        rf_t2_i = '0;
        rob_free_tag_i = 4'd1;
        rob_value_i = '0;
        rob_ready_i = '0;
        alu_full_i = 1'b0;
        cmp_full_i = 1'b0;
        lsb_full_i = 1'b0;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_val("iqueue_read_o", iqueue_read_o, 1'b0);
            check_val("load_tag_o", load_tag_o, 1'b0);
        end
        rst = 1'b0;
        check_issued();
        // instruction held through reset is taken in the first cycle
        #1;
        model_cycle(consumed);
        for (int n = 0; n < N_INSTR && !hung; n++) begin
            cur = rand_instr();
            cur_pc = $urandom & 32'hffff_fffc;
            consumed = 1'b0;
            waited = 0;
            // instruction stays in the queue until read
            while (!consumed && !hung) begin
                if (waited == MAX_WAIT) begin
                    hung = 1'b1;
                    $display("timeout: instruction %0d was never read from the queue", n);
                end else begin
                    @(negedge clk);
                    check_issued();
                    instr_i = cur;
                    pc_i = cur_pc;
                    drive_env();
                    #1;
                    model_cycle(consumed);
                    waited++;
                end
            end
        end
        @(negedge clk);
        check_issued();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !hung) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== rv32_issue.f ====
verilog/rs_issue_pkg.sv
verilog/instr_fields.sv
verilog/operand_bypass.sv
verilog/issue_ctrl.sv
verilog/issue_regs.sv
verilog/rv32_issue.sv
tests/rv32_issue_sva.sv
tests/rv32_issue_tb.sv
